// File: Bender.yml
package:
  name: kernel_top

sources:
  - rtl/kernel_pkg.sv
  - rtl/kernel_ctrl_if.sv
  - rtl/kernel_control_regs.sv
  - rtl/kernel_control.sv
  - rtl/vertex_sum_engine.sv
  - rtl/kernel_top.sv
  - target: test
    files:
      - tb/kernel_tb.sv

// File: kernel_top.f
rtl/kernel_pkg.sv
rtl/kernel_ctrl_if.sv
rtl/kernel_control_regs.sv
rtl/kernel_control.sv
rtl/vertex_sum_engine.sv
rtl/kernel_top.sv
tb/kernel_tb.sv

// File: rtl/kernel_control.sv
// Kernel launch FSM
// Walks the ap_start / ap_ready / ap_done / ap_idle sequence, forwards
// the descriptor and endian flags to the compute unit and waits for done.
// Outputs pass a per-state register and an output register

module kernel_control (
    input  logic                           ap_clk,
    input  logic                           areset_control,
    control_status_if.ctrl                 status,
    input  kernel_pkg::kernel_descriptor_t descriptor_in,
    compute_unit_if.ctrl                   cu
);

    // Registered inputs
    logic ap_start_reg;
    logic cu_done_reg;
    logic cu_setup_reg;

    // Per-state decoded values
    logic ap_ready_st;
    logic ap_done_st;
    logic ap_idle_st;
    logic start_st;
    logic descriptor_valid_st;
    logic endian_read_st;
    logic endian_write_st;

    kernel_pkg::kernel_descriptor_t descriptor_reg;
    kernel_pkg::ctrl_state_t        current_state;
    kernel_pkg::ctrl_state_t        next_state;

    // ----------------------------------------
    // Input registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            cu_done_reg  <= 1'b0;
            cu_setup_reg <= 1'b1;
        end else begin
            ap_start_reg <= status.ap_start;
            cu_done_reg  <= cu.done;
            cu_setup_reg <= cu.setup;
        end
    end

    // Descriptor copy, frozen while a run is launched or in flight
    always_ff @(posedge ap_clk) begin
        if ((current_state != kernel_pkg::ctrl_start)
            && (current_state != kernel_pkg::ctrl_busy)) begin
            descriptor_reg <= descriptor_in;
        end
    end

    assign cu.descriptor = descriptor_reg;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= kernel_pkg::ctrl_reset;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            kernel_pkg::ctrl_reset: next_state = kernel_pkg::ctrl_idle;
            kernel_pkg::ctrl_idle:  next_state = kernel_pkg::ctrl_setup;
            // Wait for the host
            kernel_pkg::ctrl_setup:
                if (ap_start_reg) next_state = kernel_pkg::ctrl_ready;
            // Wait for the engine to accept work
            kernel_pkg::ctrl_ready:
                if (cu_setup_reg) next_state = kernel_pkg::ctrl_start;
            kernel_pkg::ctrl_start: next_state = kernel_pkg::ctrl_busy;
            kernel_pkg::ctrl_busy:
                if (cu_done_reg) next_state = kernel_pkg::ctrl_done;
            // Relaunch straight from done
            kernel_pkg::ctrl_done:
                if (ap_start_reg) next_state = kernel_pkg::ctrl_ready;
            default: next_state = kernel_pkg::ctrl_reset;
        endcase
    end

    // ----------------------------------------
    // Per-state output decode
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready_st         <= 1'b0;
            ap_done_st          <= 1'b0;
            ap_idle_st          <= 1'b1;
            start_st            <= 1'b0;
            descriptor_valid_st <= 1'b0;
            endian_read_st      <= 1'b0;
            endian_write_st     <= 1'b0;
        end else begin
            // Idle values, overridden per state
            ap_ready_st         <= 1'b0;
            ap_done_st          <= 1'b0;
            ap_idle_st          <= 1'b1;
            start_st            <= 1'b0;
            descriptor_valid_st <= 1'b0;
            endian_read_st      <= 1'b0;
            endian_write_st     <= 1'b0;
            case (current_state)
                kernel_pkg::ctrl_setup: start_st <= 1'b1;
                kernel_pkg::ctrl_ready: begin
                    ap_ready_st <= 1'b1;
                    ap_idle_st  <= 1'b0;
                    start_st    <= 1'b1;
                end
                kernel_pkg::ctrl_start, kernel_pkg::ctrl_busy: begin
                    ap_idle_st          <= 1'b0;
                    start_st            <= 1'b1;
                    descriptor_valid_st <= 1'b1;
                    endian_read_st      <= descriptor_reg.flags[kernel_pkg::flag_endian_read];
                    endian_write_st     <= descriptor_reg.flags[kernel_pkg::flag_endian_write];
                end
                kernel_pkg::ctrl_done: ap_done_st <= 1'b1;
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            status.ap_ready     <= 1'b0;
            status.ap_done      <= 1'b0;
            status.ap_idle      <= 1'b1;
            cu.start            <= 1'b0;
            cu.descriptor_valid <= 1'b0;
            cu.endian_read      <= 1'b0;
            cu.endian_write     <= 1'b0;
        end else begin
            status.ap_ready     <= ap_ready_st;
            status.ap_done      <= ap_done_st;
            status.ap_idle      <= ap_idle_st;
            cu.start            <= start_st;
            cu.descriptor_valid <= descriptor_valid_st;
            cu.endian_read      <= endian_read_st;
            cu.endian_write     <= endian_write_st;
        end
    end

endmodule

// File: rtl/kernel_control_regs.sv
// Kernel register block
// Holds the descriptor fields and the start bit written by the host,
// keeps a sticky done bit, captures the result when ap_done rises
// and returns every register on the read port

module kernel_control_regs (
    input  logic                              ap_clk,
    input  logic                              areset_control,
    input  logic                              reg_write,
    input  logic [kernel_pkg::addr_width-1:0] reg_addr,
    input  logic [kernel_pkg::data_width-1:0] reg_wdata,
    output logic [kernel_pkg::data_width-1:0] reg_rdata,
    control_status_if.regs                    status,
    output kernel_pkg::kernel_descriptor_t    descriptor,
    input  logic [kernel_pkg::data_width-1:0] result
);

    logic                              start_write;
    logic                              ap_done_q;
    logic                              done_rise;
    logic                              done_sticky;
    logic [kernel_pkg::data_width-1:0] result_reg;

    // Host write to reg_ctrl with the start bit set
    assign start_write = reg_write && (reg_addr == kernel_pkg::reg_ctrl)
                         && reg_wdata[kernel_pkg::ctrl_start_bit];
    assign done_rise   = status.ap_done && !ap_done_q;

    // ----------------------------------------
    // Descriptor fields
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            descriptor <= '0;
        end else if (reg_write) begin
            case (reg_addr)
                kernel_pkg::reg_count:
                    descriptor.vertex_count <= reg_wdata[kernel_pkg::count_width-1:0];
                kernel_pkg::reg_base:
                    descriptor.vertex_base <= reg_wdata;
                kernel_pkg::reg_flags:
                    descriptor.flags <= reg_wdata[kernel_pkg::flag_width-1:0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Start level and completion status
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            status.ap_start <= 1'b0;
            ap_done_q       <= 1'b0;
            done_sticky     <= 1'b0;
            result_reg      <= '0;
        end else begin
            ap_done_q <= status.ap_done;
            // Start stays up until the control acknowledges with ap_ready
            if (start_write) begin
                status.ap_start <= 1'b1;
            end else if (status.ap_ready) begin
                status.ap_start <= 1'b0;
            end
            // New launch clears done, a finished run sets it
            if (done_rise) begin
                done_sticky <= 1'b1;
                result_reg  <= result;
            end else if (start_write) begin
                done_sticky <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            kernel_pkg::reg_ctrl: begin
                reg_rdata[kernel_pkg::ctrl_start_bit] = status.ap_start;
                reg_rdata[kernel_pkg::ctrl_done_bit]  = done_sticky;
                reg_rdata[kernel_pkg::ctrl_idle_bit]  = status.ap_idle;
                reg_rdata[kernel_pkg::ctrl_ready_bit] = status.ap_ready;
            end
            kernel_pkg::reg_count:  reg_rdata[kernel_pkg::count_width-1:0] = descriptor.vertex_count;
            kernel_pkg::reg_base:   reg_rdata = descriptor.vertex_base;
            kernel_pkg::reg_flags:  reg_rdata[kernel_pkg::flag_width-1:0] = descriptor.flags;
            kernel_pkg::reg_result: reg_rdata = result_reg;
            default: ;
        endcase
    end

endmodule

// File: rtl/kernel_ctrl_if.sv
// Kernel launch interfaces
// Launch status chain between register block and control,
// and the link between control and compute unit

interface control_status_if;
    // Level from the host side, held until ap_ready
    logic ap_start;
    logic ap_ready;
    logic ap_idle;
    logic ap_done;

    modport regs (output ap_start, input ap_ready, ap_idle, ap_done);
    modport ctrl (input ap_start, output ap_ready, ap_idle, ap_done);
endinterface

interface compute_unit_if;
    // Control to engine
    logic                              start;
    logic                              endian_read;
    logic                              endian_write;
    logic                              descriptor_valid;
    kernel_pkg::kernel_descriptor_t    descriptor;
    // Engine to control
    logic                              setup;
    logic                              done;
    logic [kernel_pkg::data_width-1:0] result;

    modport ctrl (
        output start, endian_read, endian_write, descriptor_valid, descriptor,
        input  setup, done, result
    );
    modport engine (
        input  start, endian_read, endian_write, descriptor_valid, descriptor,
        output setup, done, result
    );
endinterface

// File: rtl/kernel_pkg.sv
// Kernel launch subsystem shared definitions
// Widths, register map, control bit positions, descriptor and FSM types

package kernel_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int data_width  = 32;
    localparam int addr_width  = 3;
    localparam int count_width = 16;
    localparam int flag_width  = 2;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [addr_width-1:0] reg_ctrl   = 3'd0;
    localparam logic [addr_width-1:0] reg_count  = 3'd1;
    localparam logic [addr_width-1:0] reg_base   = 3'd2;
    localparam logic [addr_width-1:0] reg_flags  = 3'd3;
    localparam logic [addr_width-1:0] reg_result = 3'd4;

    // Bit positions inside reg_ctrl
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_done_bit  = 1;
    localparam int ctrl_idle_bit  = 2;
    localparam int ctrl_ready_bit = 3;

    // Bit positions inside the flags field
    localparam int flag_endian_read  = 0;
    localparam int flag_endian_write = 1;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    // Work item handed from the host to the compute unit
    typedef struct packed {
        logic [count_width-1:0] vertex_count;
        logic [data_width-1:0]  vertex_base;
        logic [flag_width-1:0]  flags;
    } kernel_descriptor_t;

    // Launch FSM states
    typedef enum logic [2:0] {
        ctrl_reset,
        ctrl_idle,
        ctrl_setup,
        ctrl_ready,
        ctrl_start,
        ctrl_busy,
        ctrl_done
    } ctrl_state_t;

endpackage

// File: rtl/kernel_top.sv
// Kernel launch subsystem top level
// Register block, launch FSM and vertex summing engine behind a
// simple strobed register port

module kernel_top (
    input  logic                              ap_clk,
    input  logic                              areset_control,
    input  logic                              reg_write,
    input  logic [kernel_pkg::addr_width-1:0] reg_addr,
    input  logic [kernel_pkg::data_width-1:0] reg_wdata,
    output logic [kernel_pkg::data_width-1:0] reg_rdata
);

    kernel_pkg::kernel_descriptor_t descriptor;

    // ----------------------------------------
    // Internal links
    // ----------------------------------------
    control_status_if status_if ();
    compute_unit_if   cu_if ();

    kernel_control_regs i_regs (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .status         (status_if.regs),
        .descriptor     (descriptor),
        .result         (cu_if.result)
    );

    kernel_control i_control (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .status         (status_if.ctrl),
        .descriptor_in  (descriptor),
        .cu             (cu_if.ctrl)
    );

    vertex_sum_engine i_engine (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .cu             (cu_if.engine)
    );

endmodule

// File: rtl/vertex_sum_engine.sv
// Vertex range summing engine
// Adds vertex_base + i for i in 0 .. vertex_count-1, with optional
// byte swap of each operand and of the final sum

module vertex_sum_engine (
    input  logic         ap_clk,
    input  logic         areset_control,
    compute_unit_if.engine cu
);

    typedef enum logic [1:0] {
        eng_setup,
        eng_run,
        eng_finished
    } eng_phase_t;

    eng_phase_t                         phase;
    logic [kernel_pkg::count_width-1:0] count_reg;
    logic [kernel_pkg::count_width-1:0] vertex_idx;
    logic [kernel_pkg::data_width-1:0]  base_reg;
    logic [kernel_pkg::data_width-1:0]  sum;
    logic [kernel_pkg::data_width-1:0]  operand;
    logic [kernel_pkg::data_width-1:0]  result_reg;
    logic                               endian_read_q;
    logic                               endian_write_q;

    // Reverse byte order of one word
    function automatic logic [kernel_pkg::data_width-1:0] byte_swap(
        input logic [kernel_pkg::data_width-1:0] value
    );
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    // Current vertex value, wraps modulo 2^32
    assign operand = endian_read_q ? byte_swap(base_reg + vertex_idx)
                                   : (base_reg + vertex_idx);

    assign cu.setup  = (phase == eng_setup);
    assign cu.done   = (phase == eng_finished);
    assign cu.result = result_reg;

    // ----------------------------------------
    // Phase control
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            phase <= eng_setup;
        end else begin
            case (phase)
                eng_setup:
                    if (cu.start && cu.descriptor_valid) phase <= eng_run;
                eng_run:
                    if (vertex_idx == count_reg) phase <= eng_finished;
                // Hold done until the control drops start
                eng_finished:
                    if (!cu.start) phase <= eng_setup;
                default: phase <= eng_setup;
            endcase
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (phase == eng_setup) begin
            // Latch the work item and flags at launch
            count_reg      <= cu.descriptor.vertex_count;
            base_reg       <= cu.descriptor.vertex_base;
            endian_read_q  <= cu.endian_read;
            endian_write_q <= cu.endian_write;
            vertex_idx     <= '0;
            sum            <= '0;
        end else if (phase == eng_run) begin
            if (vertex_idx == count_reg) begin
                result_reg <= endian_write_q ? byte_swap(sum) : sum;
            end else begin
                sum        <= sum + operand;
                vertex_idx <= vertex_idx + 1'b1;
            end
        end
    end

endmodule

// File: tb/kernel_tb.sv
// Kernel launch subsystem testbench
// Drives the register port, launches random vertex ranges and compares
// reg_result with a vertex sum model, with a cycle limit on the run

module kernel_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Launch budget per run plus room for the directed runs
    localparam int max_cycles = 20 * (40 + 30) + 400;

    logic        ap_clk = 1'b0;
    logic        areset_control;
    logic        reg_write;
    logic [2:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic [31:0] lcg_state = 32'd20;
    int          cycle_count = 0;

    kernel_top i_dut (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata)
    );

    always #5 ap_clk = ~ap_clk;

    // Watchdog
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Timeout: the test did not finish within %0d cycles", max_cycles);
            $display("Test FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // ----------------------------------------
    // Model and helpers
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] word);
        logic [31:0] swapped;
        for (int b = 0; b < 4; b++) begin
            swapped[8*b +: 8] = word[8*(3-b) +: 8];
        end
        return swapped;
    endfunction

    // Sum of base + i over the range with per-flag operand and result swaps
    function automatic logic [31:0] expected_sum(input logic [15:0] count,
                                                 input logic [31:0] base,
                                                 input logic [1:0]  flags);
        logic [31:0] acc;
        logic [31:0] vertex;
        acc = '0;
        for (int i = 0; i < count; i++) begin
            vertex = base + i;
            if (flags[0]) vertex = swap_bytes(vertex);
            acc = acc + vertex;
        end
        if (flags[1]) acc = swap_bytes(acc);
        return acc;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ----------------------------------------
    // Register port access
    // ----------------------------------------
    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        @(negedge ap_clk);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge ap_clk);
        reg_write = 1'b0;
    endtask

    // Combinational read data sampled shortly after the address settles
    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        @(negedge ap_clk);
        reg_addr = addr;
        #1;
        data = reg_rdata;
    endtask

    task automatic launch(input logic [15:0] count, input logic [31:0] base,
                          input logic [1:0] flags);
        write_reg(kernel_pkg::reg_count, {16'd0, count});
        write_reg(kernel_pkg::reg_base, base);
        write_reg(kernel_pkg::reg_flags, {30'd0, flags});
        write_reg(kernel_pkg::reg_ctrl, 32'(1) << kernel_pkg::ctrl_start_bit);
    endtask

    task automatic wait_done();
        logic [31:0] ctrl;
        do read_reg(kernel_pkg::reg_ctrl, ctrl);
        while (!ctrl[kernel_pkg::ctrl_done_bit]);
    endtask

    task automatic run_and_check(input logic [15:0] count, input logic [31:0] base,
                                 input logic [1:0] flags, input string what);
        logic [31:0] result;
        launch(count, base, flags);
        wait_done();
        read_reg(kernel_pkg::reg_result, result);
        check_value(result, expected_sum(count, base, flags), what);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] value;
        logic [31:0] rnd;
        logic [15:0] count;
        logic [31:0] base;
        logic [1:0]  flags;

        areset_control = 1'b1;
        reg_write      = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        repeat (3) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_control = 1'b0;

        // Only idle set out of reset
        read_reg(kernel_pkg::reg_ctrl, value);
        check_value(value, 32'(1) << kernel_pkg::ctrl_idle_bit, "control after reset");

        // Descriptor fields keep only their own width
        write_reg(kernel_pkg::reg_count, 32'h1234_abcd);
        write_reg(kernel_pkg::reg_base, 32'hdead_beef);
        write_reg(kernel_pkg::reg_flags, 32'hffff_ffff);
        read_reg(kernel_pkg::reg_count, value);
        check_value(value, 32'h0000_abcd, "count readback");
        read_reg(kernel_pkg::reg_base, value);
        check_value(value, 32'hdead_beef, "base readback");
        read_reg(kernel_pkg::reg_flags, value);
        check_value(value, 32'h0000_0003, "flags readback");

        // Random launches where the first four cover every flag pair
        for (int i = 0; i < 20; i++) begin
            count = 16'((next_random() >> 8) % 41);
            base  = next_random();
            rnd   = next_random();
            flags = (i < 4) ? 2'(i) : rnd[17:16];
            run_and_check(count, base, flags, $sformatf("random run %0d", i));
        end

        // Empty range, start acknowledged and done held
        run_and_check(16'd0, next_random(), 2'b11, "zero count result");
        read_reg(kernel_pkg::reg_ctrl, value);
        check_value(32'({value[kernel_pkg::ctrl_done_bit], value[kernel_pkg::ctrl_start_bit]}),
                    32'b10, "zero count done and start");

        // Relaunch from done, then rewrite the descriptor mid run
        launch(16'd30, 32'h0102_0304, 2'b01);
        read_reg(kernel_pkg::reg_ctrl, value);
        check_value(32'(value[kernel_pkg::ctrl_done_bit]), 32'd0, "done cleared on relaunch");
        do read_reg(kernel_pkg::reg_ctrl, value);
        while (value[kernel_pkg::ctrl_start_bit] || value[kernel_pkg::ctrl_idle_bit]);
        write_reg(kernel_pkg::reg_count, 32'd12);
        write_reg(kernel_pkg::reg_base, 32'h8000_0000);
        write_reg(kernel_pkg::reg_flags, 32'd2);
        wait_done();
        read_reg(kernel_pkg::reg_result, value);
        check_value(value, expected_sum(16'd30, 32'h0102_0304, 2'b01), "run in flight");

        // Second launch picks up the rewritten descriptor
        write_reg(kernel_pkg::reg_ctrl, 32'(1) << kernel_pkg::ctrl_start_bit);
        read_reg(kernel_pkg::reg_ctrl, value);
        check_value(32'(value[kernel_pkg::ctrl_done_bit]), 32'd0, "done cleared again");
        wait_done();
        read_reg(kernel_pkg::reg_result, value);
        check_value(value, expected_sum(16'd12, 32'h8000_0000, 2'b10), "back to back run");

        $display("Test OK");
        $finish;
    end

endmodule
